// ==== hw/stq_entry_pkg.sv ====
// Sizing and stored-shape types for the store-queue entry array.
// Imported by the entry, compare and top-level modules.
`default_nettype none

package stq_entry_pkg;

  // store-queue depth
  localparam int NUM_ENTRIES = 8;

  // low address bits kept per store, enough to separate the words inside a bank line
  localparam int ODD_W = 4;

  localparam int BYTE_LANES = 4;  // one lane per byte of the 32-bit store word

  // one bit per entry, used for strobes, flags and check results alike
  typedef logic [NUM_ENTRIES-1:0] entry_vec_t;

  // what an entry remembers about its store
  // odd[0] picks the even or odd half of the access
  // sub_bnk2 qualifies the coarse bank hit and sub_bnk the exact one
  typedef struct packed {
    logic [ODD_W-1:0]      odd;
    logic [BYTE_LANES-1:0] bytes;   // lanes written by the store
    logic                  sub_bnk;
    logic                  sub_bnk2;
  } st_shape_t;

endpackage

`default_nettype wire

// ==== hw/stq_chk_pkg.sv ====
// Types for the load-forwarding check ports of the store-queue array.
// A check carries a request shape plus one even/odd hit pair per entry,
// and returns match or partial for each entry.
`default_nettype none

package stq_chk_pkg;

  import stq_entry_pkg::*;

  localparam int NUM_CHK = 2;  // load ports probing the queue in parallel

  localparam int EO_W = 2;

  // external address compare per entry
  // bit 0 is the hit for an even access and bit 1 for an odd access
  typedef logic [EO_W-1:0] eo_hit_t;

  // one load probing the queue
  typedef struct packed {
    logic      en;
    st_shape_t shape;
  } chk_req_t;

  // per-entry answer to one load
  typedef struct packed {
    logic match;    // entry covers the load and its data is ready
    logic partial;  // entry overlaps the load, so the load has to stall
  } chk_res_t;

endpackage

`default_nettype wire

// ==== hw/stq_entry_state.sv ====
// Holds one store-queue entry: the shape of its store and its lifecycle flags.
// All strobes are one cycle wide and take effect at the next rising edge.
// When several strobes hit in one cycle the later steps of the update win.
`timescale 1ns/1ns
`default_nettype none

module stq_entry_state
  import stq_entry_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            wrt_en,
  input  wire            upd_en,
  input  wire            passe_en,
  input  wire            free_en,
  input  wire            excpt,
  input  wire st_shape_t wrt_shape,
  output st_shape_t      shape,
  output logic           free,
  output logic           upd,
  output logic           passe
);

  // a reset entry is empty and reads as updated, so it never stalls a load
  always_ff @(posedge clk) begin
    if (rst) begin
      shape <= '0;
      free  <= 1'b1;
      upd   <= 1'b1;
      passe <= 1'b0;
    end else begin
      if (wrt_en) begin
        shape <= wrt_shape;
        free  <= 1'b0;
        passe <= 1'b0;  // upd stays as it is until the data arrives
      end

      if (upd_en) begin
        upd <= 1'b1;
      end

      // a passed store has left for the cache and its data is no longer held here
      if (passe_en) begin
        passe <= 1'b1;
        upd   <= 1'b0;
      end

      if (free_en) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end

      // on a flush only entries already released and passed drop the pass mark
      if (excpt && free && passe) begin
        passe <= 1'b0;
      end
    end
  end

  // the allocator hands out entries only after they have been released
  a_wrt_to_free: assert property (@(posedge clk) disable iff (rst)
    wrt_en |-> free)
    else $error("write strobe on an entry that is still allocated");

  // a release without an allocation in between means a lost store
  a_free_once: assert property (@(posedge clk) disable iff (rst)
    free_en |-> !free)
    else $error("free strobe on an entry that is already free");

endmodule

`default_nettype wire

// ==== hw/stq_fwd_cmp.sv ====
// Compares one load check against one store-queue entry.
// Gives match when the entry can forward the whole load and partial when it
// only overlaps or its data is not there yet. Purely combinational.
`timescale 1ns/1ns
`default_nettype none

module stq_fwd_cmp
  import stq_entry_pkg::*;
  import stq_chk_pkg::*;
(
  input  wire chk_req_t  req,
  input  wire eo_hit_t   eo,
  input  wire st_shape_t shape,
  input  wire            free,
  input  wire            upd,
  input  wire            passe,
  output chk_res_t       res
);

  logic base_hit;
  logic live;
  logic covered;
  logic addr_eq;
  logic bnk_eq;

  // the coarse hit needs the external compare for the right half and the same bank group
  assign base_hit = eo[req.shape.odd[0]]
                 && req.shape.sub_bnk2 && shape.sub_bnk2
                 && (req.shape.odd[0] == shape.odd[0]);

  assign live = base_hit && req.en && !free && !passe;  // only held stores count

  assign covered = ((req.shape.bytes & ~shape.bytes) == '0);

  assign addr_eq = (req.shape.odd == shape.odd);
  assign bnk_eq  = req.shape.sub_bnk && shape.sub_bnk;

  always_comb begin
    res.match   = live && covered && upd && addr_eq && bnk_eq;
    // missing lanes or data still to come means the load has to wait
    res.partial = live && (!covered || !upd);
  end

endmodule

`default_nettype wire

// ==== hw/stq_buf_array.sv ====
// Top level of the store-queue entry array with load-forwarding checks.
// Builds one state block per entry and one compare per entry and check port;
// results come back as one match and one partial vector per check port.
`timescale 1ns/1ns
`default_nettype none

module stq_buf_array
  import stq_entry_pkg::*;
  import stq_chk_pkg::*;
(
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire entry_vec_t                              wrt_en,
  input  wire st_shape_t                               wrt_shape,
  input  wire entry_vec_t                              upd_en,
  input  wire entry_vec_t                              passe_en,
  input  wire entry_vec_t                              free_en,
  input  wire                                          excpt,
  input  wire chk_req_t [NUM_CHK-1:0]                  chk_req,
  input  wire eo_hit_t  [NUM_CHK-1:0][NUM_ENTRIES-1:0] chk_eo,
  output entry_vec_t [NUM_CHK-1:0]                     chk_match,
  output entry_vec_t [NUM_CHK-1:0]                     chk_partial,
  output entry_vec_t                                   free,
  output entry_vec_t                                   upd,
  output entry_vec_t                                   passe
);

  st_shape_t [NUM_ENTRIES-1:0]            ent_shape;
  chk_res_t  [NUM_CHK-1:0][NUM_ENTRIES-1:0] res_grid;

  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    // excpt is broadcast, each entry decides for itself whether it applies
    stq_entry_state u_entry (
      .clk       (clk),
      .rst       (rst),
      .wrt_en    (wrt_en[e]),
      .upd_en    (upd_en[e]),
      .passe_en  (passe_en[e]),
      .free_en   (free_en[e]),
      .excpt     (excpt),
      .wrt_shape (wrt_shape),
      .shape     (ent_shape[e]),
      .free      (free[e]),
      .upd       (upd[e]),
      .passe     (passe[e])
    );

    // every check port sees every entry in the same cycle
    for (genvar c = 0; c < NUM_CHK; c++) begin : g_chk
      stq_fwd_cmp u_cmp (
        .req   (chk_req[c]),
        .eo    (chk_eo[c][e]),
        .shape (ent_shape[e]),
        .free  (free[e]),
        .upd   (upd[e]),
        .passe (passe[e]),
        .res   (res_grid[c][e])
      );
    end
  end

  // split the result grid into per-port entry vectors
  always_comb begin
    for (int c = 0; c < NUM_CHK; c++) begin
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        chk_match[c][e]   = res_grid[c][e].match;
        chk_partial[c][e] = res_grid[c][e].partial;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/stq_ref_model.svh ====
// Reference model of the store-queue entry array, included inside the testbench module.
// It reads the DUT inputs directly, steps once per rising edge and answers the
// compare rules for any check against any modelled entry.
`ifndef STQ_REF_MODEL_SVH
`define STQ_REF_MODEL_SVH

st_shape_t  m_shape [NUM_ENTRIES];
entry_vec_t m_free;
entry_vec_t m_upd;
entry_vec_t m_passe;

// called right after a rising edge, so the inputs still hold the values sampled there
task automatic model_step();
  entry_vec_t was_free;
  entry_vec_t was_passe;
  was_free  = m_free;
  was_passe = m_passe;
  for (int e = 0; e < NUM_ENTRIES; e++) begin
    if (rst) begin
      m_shape[e] = '0;
      m_free[e]  = 1'b1;
      m_upd[e]   = 1'b1;
      m_passe[e] = 1'b0;
    end else begin
      if (wrt_en[e]) begin
        m_shape[e] = wrt_shape;
        m_free[e]  = 1'b0;
        m_passe[e] = 1'b0;
      end
      if (upd_en[e]) m_upd[e] = 1'b1;
      if (passe_en[e]) begin
        m_passe[e] = 1'b1;
        m_upd[e]   = 1'b0;
      end
      if (free_en[e]) begin
        m_free[e]  = 1'b1;
        m_passe[e] = 1'b0;
      end
      // flush looks at the flags as they were before this edge
      if (excpt && was_free[e] && was_passe[e]) m_passe[e] = 1'b0;
    end
  end
endtask

function automatic chk_res_t model_cmp(input chk_req_t req, input eo_hit_t eo, input int e);
  chk_res_t res;
  logic     half;
  logic     live;
  logic     covered;
  half = req.shape.odd[0];
  live = eo[half] && req.shape.sub_bnk2 && m_shape[e].sub_bnk2
      && (half == m_shape[e].odd[0]) && req.en && !m_free[e] && !m_passe[e];
  covered = 1'b1;
  for (int b = 0; b < BYTE_LANES; b++) begin
    if (req.shape.bytes[b] && !m_shape[e].bytes[b]) covered = 1'b0;  // lane the store lacks
  end
  res.match = live && covered && m_upd[e] && (req.shape.odd == m_shape[e].odd)
           && req.shape.sub_bnk && m_shape[e].sub_bnk;
  res.partial = live && (!covered || !m_upd[e]);
  return res;
endfunction

`endif

// ==== verification/stq_buf_array_tb.sv ====
// Testbench for the store-queue entry array.
// Runs directed lifecycle sequences, then random strobes and checks, and compares
// every output on each falling edge with the included reference model.
`timescale 1ns/1ns
`default_nettype none

module stq_buf_array_tb
  import stq_entry_pkg::*;
  import stq_chk_pkg::*;
();

  localparam int RST_CYCLES   = 4;
  localparam int RST_WAIT_MAX = 16;
  localparam int RAND_CYCLES  = 2000;

  logic                                   clk;
  logic                                   rst;
  entry_vec_t                             wrt_en;
  st_shape_t                              wrt_shape;
  entry_vec_t                             upd_en;
  entry_vec_t                             passe_en;
  entry_vec_t                             free_en;
  logic                                   excpt;
  chk_req_t  [NUM_CHK-1:0]                chk_req;
  eo_hit_t   [NUM_CHK-1:0][NUM_ENTRIES-1:0] chk_eo;
  entry_vec_t [NUM_CHK-1:0]               chk_match;
  entry_vec_t [NUM_CHK-1:0]               chk_partial;
  entry_vec_t                             free;
  entry_vec_t                             upd;
  entry_vec_t                             passe;
  integer                                 seed;

  `include "stq_ref_model.svh"

  stq_buf_array u_stq_buf_array (
    .clk         (clk),
    .rst         (rst),
    .wrt_en      (wrt_en),
    .wrt_shape   (wrt_shape),
    .upd_en      (upd_en),
    .passe_en    (passe_en),
    .free_en     (free_en),
    .excpt       (excpt),
    .chk_req     (chk_req),
    .chk_eo      (chk_eo),
    .chk_match   (chk_match),
    .chk_partial (chk_partial),
    .free        (free),
    .upd         (upd),
    .passe       (passe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task check_flags(input string what, input entry_vec_t got, input entry_vec_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s flags expected %b got %b", $time, what, exp, got);
      stop_on_failure();
    end
  endtask

  task check_chk(input int port, input entry_vec_t got_match, input entry_vec_t got_partial,
                 input entry_vec_t exp_match, input entry_vec_t exp_partial);
    if (got_match !== exp_match || got_partial !== exp_partial) begin
      $display("[FAIL] %0t ns: check %0d match/partial expected %b/%b got %b/%b", $time,
               port, exp_match, exp_partial, got_match, got_partial);
      stop_on_failure();
    end
  endtask

  task compare_all();
    entry_vec_t exp_m;
    entry_vec_t exp_p;
    chk_res_t   r;
    check_flags("free", free, m_free);
    check_flags("upd", upd, m_upd);
    check_flags("passe", passe, m_passe);
    for (int c = 0; c < NUM_CHK; c++) begin
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        r = model_cmp(chk_req[c], chk_eo[c][e], e);
        exp_m[e] = r.match;
        exp_p[e] = r.partial;
      end
      check_chk(c, chk_match[c], chk_partial[c], exp_m, exp_p);
    end
  endtask

  task advance();
    @(posedge clk);
    model_step();
  endtask

  task settle();
    @(negedge clk);
    compare_all();
  endtask

  task clear_strobes();
    wrt_en   <= '0;
    upd_en   <= '0;
    passe_en <= '0;
    free_en  <= '0;
    excpt    <= 1'b0;
  endtask

  // strobes driven at this edge land on the next one, after which we sit at a falling edge
  task pulse();
    settle();
    advance();
    clear_strobes();
    settle();
  endtask

  function entry_vec_t rand_vec();
    integer r;
    r = $random(seed);
    return r[NUM_ENTRIES-1:0];
  endfunction

  function int rand_index();
    integer r;
    r = $random(seed);
    return r[2:0];  // NUM_ENTRIES is 8
  endfunction

  function st_shape_t rand_shape();
    integer    r;
    st_shape_t sh;
    r = $random(seed);
    sh.odd      = r[3:0];
    sh.bytes    = r[7:4];
    sh.sub_bnk  = (r[9:8] != 2'b00);  // mostly set so full matches happen
    sh.sub_bnk2 = (r[11:10] != 2'b00);
    return sh;
  endfunction

  function st_shape_t make_shape(input logic [ODD_W-1:0] odd, input logic [BYTE_LANES-1:0] lanes);
    st_shape_t sh;
    sh.odd      = odd;
    sh.bytes    = lanes;
    sh.sub_bnk  = 1'b1;
    sh.sub_bnk2 = 1'b1;
    return sh;
  endfunction

  task set_check(input int port, input st_shape_t sh);
    chk_req[port].en    <= 1'b1;
    chk_req[port].shape <= sh;
    for (int e = 0; e < NUM_ENTRIES; e++) chk_eo[port][e] <= 2'b11;
  endtask

  task drive_random();
    integer     r;
    int         idx;
    entry_vec_t wv;
    st_shape_t  sh;
    r  = $random(seed);
    wv = '0;
    // writes go only to entries that are free, as the allocator guarantees
    if (r[1:0] != 2'b00 && m_free != '0) begin
      idx = rand_index();
      for (int k = 0; k < NUM_ENTRIES && !m_free[idx]; k++) idx = (idx + 1) % NUM_ENTRIES;
      wv[idx] = 1'b1;
    end
    wrt_en    <= wv;
    wrt_shape <= rand_shape();
    upd_en    <= rand_vec() & rand_vec();
    passe_en  <= rand_vec() & rand_vec() & rand_vec();
    free_en   <= rand_vec() & rand_vec() & ~m_free;
    excpt     <= (r[5:2] == 4'h0);
    for (int c = 0; c < NUM_CHK; c++) begin
      r  = $random(seed);
      sh = r[0] ? m_shape[rand_index()] : rand_shape();  // aim at a live entry half the time
      if (r[1]) sh.bytes = r[5:2];
      chk_req[c].en    <= (r[7:6] != 2'b00);
      chk_req[c].shape <= sh;
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        r = $random(seed);
        chk_eo[c][e] <= (r[3:2] == 2'b00) ? r[1:0] : 2'b11;
      end
    end
  endtask

  initial begin
    int waited;
    seed      = 32'h6b891eac;
    rst       = 1'b1;
    wrt_en    = '0;
    wrt_shape = '0;
    upd_en    = '0;
    passe_en  = '0;
    free_en   = '0;
    excpt     = 1'b0;
    chk_req   = '0;
    chk_eo    = '0;
    waited    = 0;

    repeat (RST_CYCLES) advance();
    rst <= 1'b0;
    @(negedge clk);
    while (free !== '1 || upd !== '1 || passe !== '0) begin
      if (waited >= RST_WAIT_MAX) begin
        $display("entries did not leave reset within %0d cycles", RST_WAIT_MAX);
        stop_on_failure();
      end
      waited++;
      advance();
      @(negedge clk);
    end
    advance();

    // empty queue answers nothing, whatever the load asks for
    repeat (4) begin
      for (int c = 0; c < NUM_CHK; c++) set_check(c, rand_shape());
      settle();
      check_flags("free", free, '1);
      check_flags("upd", upd, '1);
      check_flags("passe", passe, '0);
      for (int c = 0; c < NUM_CHK; c++) check_chk(c, chk_match[c], chk_partial[c], '0, '0);
      advance();
    end

    set_check(0, make_shape(4'h5, 4'h3));
    set_check(1, make_shape(4'h5, 4'hf));
    wrt_en    <= 8'h08;
    wrt_shape <= make_shape(4'h5, 4'hf);
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h08, 8'h00);
    advance();
    free_en <= 8'h08;
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h00, 8'h00);
    advance();
    wrt_en    <= 8'h08;
    wrt_shape <= make_shape(4'h5, 4'h2);  // lane 0 missing from the store
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h00, 8'h08);
    advance();

    // pass, release and reallocate leaves the entry waiting for its data
    passe_en <= 8'h08;
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h00, 8'h00);
    advance();
    free_en <= 8'h08;
    pulse();
    advance();
    wrt_en    <= 8'h08;
    wrt_shape <= make_shape(4'h5, 4'hf);
    pulse();
    check_flags("upd", upd, 8'hf7);
    check_chk(0, chk_match[0], chk_partial[0], 8'h00, 8'h08);
    advance();
    upd_en <= 8'h08;
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h08, 8'h00);
    advance();

    wrt_en    <= 8'h20;
    wrt_shape <= make_shape(4'h5, 4'hf);
    passe_en  <= 8'h08;
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h20, 8'h00);
    advance();
    free_en <= 8'h20;
    pulse();
    check_chk(0, chk_match[0], chk_partial[0], 8'h00, 8'h00);
    advance();
    passe_en <= 8'h20;
    pulse();
    check_flags("passe", passe, 8'h28);
    advance();
    excpt <= 1'b1;  // entry 5 is free and passed, entry 3 is only passed
    pulse();
    check_flags("passe", passe, 8'h08);
    advance();

    for (int n = 0; n < RAND_CYCLES; n++) begin
      drive_random();
      settle();
      advance();
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
hw/stq_entry_pkg.sv
hw/stq_chk_pkg.sv
hw/stq_entry_state.sv
hw/stq_fwd_cmp.sv
hw/stq_buf_array.sv
verification/stq_buf_array_tb.sv
